/* src/eboxPkg.sv */
package eboxPkg;

  localparam int CRAM_ADDR_W = 10;
  localparam int CRAM_DEPTH  = 1 << CRAM_ADDR_W;   // 1024 microwords
  localparam int CRAM_WORD_W = 24;
  localparam int HALF_W      = 18;                 // Half of a 36-bit word
  localparam int DIAG_W      = 24;
  localparam int BOARD_W     = 4;
  localparam int FUNC_W      = 3;
  localparam int RATE_W      = 2;
  localparam int PRESCALE_W  = (1 << RATE_W) - 1;  // Enough for divide by 8

  // Microword layout is op, jump, imm from the top down
  localparam int OP_W     = 4;
  localparam int IMM_W    = 10;
  localparam int OP_LSB   = CRAM_WORD_W - OP_W;
  localparam int JUMP_LSB = IMM_W;

  typedef logic [CRAM_ADDR_W-1:0] cramAddrT;
  typedef logic [CRAM_WORD_W-1:0] cramWordT;
  typedef logic [HALF_W-1:0]      halfWordT;
  typedef logic [DIAG_W-1:0]      diagDataT;
  typedef logic [BOARD_W-1:0]     boardSelT;
  typedef logic [RATE_W-1:0]      rateT;
  typedef logic [IMM_W-1:0]       immT;

  localparam boardSelT BOARD_CLK  = 4'd0;
  localparam boardSelT BOARD_CRAM = 4'd1;

  typedef enum logic [FUNC_W-1:0] {
    clkNop      = 3'd0,
    clkStart    = 3'd1,
    clkStop     = 3'd2,
    clkStep     = 3'd3,
    clkSetRate  = 3'd4,  // Rate in data bits 1..0
    clkClrReset = 3'd6,
    clkSetReset = 3'd7
  } clkFuncE;

  typedef enum logic [FUNC_W-1:0] {
    cramLoadAddr = 3'd0,
    cramWrite    = 3'd1,
    cramRead     = 3'd2
  } cramFuncE;

  typedef enum logic [OP_W-1:0] {
    uNop     = 4'd0,
    uJump    = 4'd1,
    uAddImm  = 4'd2,
    uLoadImm = 4'd3,
    uHalt    = 4'd4
  } uOpE;

  typedef enum logic [1:0] {
    seqIdle,
    seqFetch,
    seqExec,
    seqHalted
  } seqStateE;

  function automatic uOpE opOf(cramWordT w);
    return uOpE'(w[OP_LSB +: OP_W]);
  endfunction

  function automatic cramAddrT jumpOf(cramWordT w);
    return w[JUMP_LSB +: CRAM_ADDR_W];
  endfunction

  function automatic immT immOf(cramWordT w);
    return w[IMM_W-1:0];
  endfunction

endpackage

/* src/diagBusIf.sv */
interface diagBusIf import eboxPkg::*; ();

  logic                cmdValid;  // One cycle per strobe
  boardSelT            board;
  logic [FUNC_W-1:0]   func;      // Board specific function code
  diagDataT            data;

  // Decoder side
  modport master (
    output cmdValid,
    output board,
    output func,
    output data
  );

  // Clock and CRAM boards
  modport slave (
    input cmdValid,
    input board,
    input func,
    input data
  );

endinterface

/* src/diagDecode.sv */
module diagDecode import eboxPkg::*; (
  input  logic       masterClk,
  input  logic       arstN,
  input  logic       diagStrobe,
  input  logic [6:0] diagFunc,
  input  diagDataT   diagData,
  diagBusIf.master   bus
);

  logic [1:0] strobeSync;   // Two-stage synchronizer
  logic       strobeLast;   // Previous synchronized level
  logic       strobeRise;

  // Front end strobe is a slow level from another domain
  assign strobeRise = strobeSync[1] && !strobeLast;

  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      strobeSync <= '0;
      strobeLast <= 1'b0;
    end else begin
      strobeSync <= {strobeSync[0], diagStrobe};
      strobeLast <= strobeSync[1];
    end
  end

  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      bus.cmdValid <= 1'b0;
    end else begin
      bus.cmdValid <= strobeRise;  // Third edge after first sample
    end
  end

  // Function and data are steady while the strobe is high
  always_ff @(posedge masterClk) begin
    if (strobeRise) begin
      bus.board <= diagFunc[FUNC_W +: BOARD_W];  // Upper 4 bits
      bus.func  <= diagFunc[FUNC_W-1:0];
      bus.data  <= diagData;
    end
  end

  // A held strobe must yield a single command
  cmdSinglePulse: assert property (
    @(posedge masterClk) disable iff (!arstN)
    bus.cmdValid |=> !bus.cmdValid
  );

endmodule

/* src/clkCtl.sv */
module clkCtl import eboxPkg::*; (
  input  logic    masterClk,
  input  logic    arstN,
  input  logic    crobar,
  diagBusIf.slave bus,
  input  logic    haltReq,
  output logic    machReset,
  output logic    running,
  output logic    tick
);

  clkFuncE               func;
  logic                  clkCmd;
  logic                  stepReq;   // One-shot from a step command
  rateT                  rate;
  logic [PRESCALE_W-1:0] divCnt;
  logic [PRESCALE_W-1:0] rateMask;
  logic                  runTick;

  assign clkCmd = bus.cmdValid && (bus.board == BOARD_CLK);
  assign func   = clkFuncE'(bus.func);

  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      machReset <= 1'b1;
      running   <= 1'b0;
      rate      <= '0;
      stepReq   <= 1'b0;
    end else if (crobar) begin  // Power-on clear
      machReset <= 1'b1;
      running   <= 1'b0;
      rate      <= '0;
      stepReq   <= 1'b0;
    end else begin
      stepReq <= 1'b0;
      if (haltReq) begin
        running <= 1'b0;        // Sequencer hit a halt
      end
      if (clkCmd) begin
        case (func)
          clkStart:    running   <= 1'b1;
          clkStop:     running   <= 1'b0;
          clkStep:     stepReq   <= 1'b1;
          clkSetRate:  rate      <= bus.data[RATE_W-1:0];
          clkClrReset: machReset <= 1'b0;
          clkSetReset: machReset <= 1'b1;
          default:     ;        // Nop and unused codes
        endcase
      end
    end
  end

  // Prescaler only counts while running so every start has the same phase
  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      divCnt <= '0;
    end else if (crobar || !running || machReset) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  assign rateMask = ~({PRESCALE_W{1'b1}} << rate);  // 2^rate - 1
  assign runTick  = running && ((divCnt & rateMask) == rateMask);
  assign tick     = !machReset && (runTick || stepReq);

  noTickInReset: assert property (
    @(posedge masterClk) disable iff (!arstN)
    machReset |-> !tick
  );

endmodule

/* src/cramStore.sv */
module cramStore import eboxPkg::*; (
  input  logic     masterClk,
  input  logic     arstN,
  diagBusIf.slave  bus,
  input  logic     machReset,
  input  cramAddrT fetchAddr,
  output cramWordT fetchWord,
  output diagDataT diagRdata
);

  cramWordT mem [CRAM_DEPTH];
  cramAddrT diagAddr;        // Diagnostic address counter
  cramFuncE func;
  logic     cramCmd;
  logic     cramWe;
  logic     cramRe;

  assign cramCmd = bus.cmdValid && (bus.board == BOARD_CRAM);
  assign func    = cramFuncE'(bus.func);
  assign cramWe  = cramCmd && (func == cramWrite) && machReset;  // Only in reset
  assign cramRe  = cramCmd && (func == cramRead);

  always_ff @(posedge masterClk) begin
    if (cramWe) begin
      mem[diagAddr] <= bus.data;
    end
    fetchWord <= mem[fetchAddr];  // Sequencer port
  end

  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      diagAddr  <= '0;
      diagRdata <= '0;
    end else begin
      if (cramCmd && (func == cramLoadAddr)) begin
        diagAddr <= bus.data[CRAM_ADDR_W-1:0];
      end else if (cramWe || cramRe) begin
        diagAddr <= diagAddr + 1'b1;  // Auto increment
      end
      if (cramRe) begin
        diagRdata <= mem[diagAddr];
      end
    end
  end

  // A write command outside machine reset leaves the addressed word alone
  noWriteOutOfReset: assert property (
    @(posedge masterClk) disable iff (!arstN)
    (cramCmd && (func == cramWrite) && !machReset)
      |=> (mem[$past(diagAddr)] === $past(mem[diagAddr]))
  );

endmodule

/* src/microSeq.sv */
module microSeq import eboxPkg::*; (
  input  logic     masterClk,
  input  logic     arstN,
  input  logic     machReset,
  input  logic     tick,
  input  cramWordT fetchWord,
  output cramAddrT fetchAddr,
  output cramAddrT uPc,
  output halfWordT acc,
  output logic     halted,
  output logic     haltReq
);

  seqStateE state;
  uOpE      op;
  cramAddrT jumpAddr;
  halfWordT immVal;
  cramAddrT nextPc;
  logic     execNow;

  assign op       = opOf(fetchWord);
  assign jumpAddr = jumpOf(fetchWord);
  assign immVal   = halfWordT'(immOf(fetchWord));  // Zero extended
  assign execNow  = tick && (state == seqExec);

  always_comb begin
    case (op)
      uJump:   nextPc = jumpAddr;
      uHalt:   nextPc = uPc;         // Hold on halt
      default: nextPc = uPc + 1'b1;  // Nop and unknown ops fall through
    endcase
  end

  // Address the next word while executing so it is ready for the next tick
  assign fetchAddr = execNow ? nextPc : uPc;

  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      state <= seqIdle;
      uPc   <= '0;
      acc   <= '0;
    end else if (machReset) begin
      state <= seqIdle;
      uPc   <= '0;
      acc   <= '0;
    end else begin
      case (state)
        seqIdle: begin
          if (tick) begin
            state <= seqFetch;  // First tick primes the pipeline
          end
        end
        seqFetch: begin
          state <= seqExec;     // Word at uPc is now registered
        end
        seqExec: begin
          if (tick) begin
            uPc <= nextPc;
            case (op)
              uAddImm:  acc   <= acc + immVal;  // Wraps mod 2^18
              uLoadImm: acc   <= immVal;
              uHalt:    state <= seqHalted;
              default:  ;
            endcase
          end
        end
        default: ;              // Halted until machine reset
      endcase
    end
  end

  assign halted  = (state == seqHalted);
  assign haltReq = execNow && (op == uHalt);  // Drops run on the clock board

  // Architectural state only moves on a tick
  stableWithoutTick: assert property (
    @(posedge masterClk) disable iff (!arstN || machReset)
    !tick |=> ($stable(acc) && $stable(uPc))
  );

endmodule

/* src/eboxTop.sv */
module eboxTop import eboxPkg::*; (
  input  logic       masterClk,
  input  logic       arstN,
  input  logic       crobar,
  input  logic       diagStrobe,
  input  logic [6:0] diagFunc,    // Board in 6..3, function in 2..0
  input  diagDataT   diagData,
  output diagDataT   diagRdata,
  output logic       machReset,
  output logic       running,
  output logic       halted,
  output cramAddrT   uPc,
  output halfWordT   acc
);

  diagBusIf diagBus ();

  logic     tick;
  logic     haltReq;
  cramAddrT fetchAddr;
  cramWordT fetchWord;

  diagDecode decoder (
    .masterClk  (masterClk),
    .arstN      (arstN),
    .diagStrobe (diagStrobe),
    .diagFunc   (diagFunc),
    .diagData   (diagData),
    .bus        (diagBus.master)
  );

  clkCtl clockBoard (
    .masterClk (masterClk),
    .arstN     (arstN),
    .crobar    (crobar),
    .bus       (diagBus.slave),
    .haltReq   (haltReq),
    .machReset (machReset),
    .running   (running),
    .tick      (tick)
  );

  cramStore cramBoard (
    .masterClk (masterClk),
    .arstN     (arstN),
    .bus       (diagBus.slave),
    .machReset (machReset),
    .fetchAddr (fetchAddr),
    .fetchWord (fetchWord),
    .diagRdata (diagRdata)
  );

  microSeq sequencer (
    .masterClk (masterClk),
    .arstN     (arstN),
    .machReset (machReset),
    .tick      (tick),
    .fetchWord (fetchWord),
    .fetchAddr (fetchAddr),
    .uPc       (uPc),
    .acc       (acc),
    .halted    (halted),
    .haltReq   (haltReq)
  );

endmodule

/* dv/eboxTb.sv */
module eboxTb import eboxPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CMD_CYCLES   = 16;   // Strobe 8 high then 8 low
  localparam int PROG_WORDS   = 16;
  localparam int HALT_BOUND   = 64;
  localparam int RUN_WINDOW   = 20;
  localparam int HOLD_WINDOW  = 20;
  localparam int RATE_SEL     = 3;
  localparam int RATE_WINDOW  = 160;
  localparam int TOTAL_CMDS   = 34 + 7 + 11 + 2 + 17;
  localparam int TOTAL_WINDOW = 8 + HALT_BOUND + RUN_WINDOW + HOLD_WINDOW + RATE_WINDOW + 8;
  localparam int WATCHDOG_CYCLES = 2 * (TOTAL_CMDS * CMD_CYCLES + TOTAL_WINDOW);

  logic       masterClk;
  logic       arstN;
  logic       crobar;
  logic       diagStrobe;
  logic [6:0] diagFunc;
  diagDataT   diagData;
  diagDataT   diagRdata;
  logic       machReset;
  logic       running;
  logic       halted;
  cramAddrT   uPc;
  halfWordT   acc;

  integer   seed = 32'ha95836bb;
  cramWordT shadow [CRAM_DEPTH];   // Expected CRAM contents
  cramAddrT shadowAddr;            // Mirrors the diagnostic address counter
  string    curTest;
  int       errCount;
  int       testErrs;
  int       testsRun;
  int       testsFailed;

  eboxTop DUT (
    .masterClk  (masterClk),
    .arstN      (arstN),
    .crobar     (crobar),
    .diagStrobe (diagStrobe),
    .diagFunc   (diagFunc),
    .diagData   (diagData),
    .diagRdata  (diagRdata),
    .machReset  (machReset),
    .running    (running),
    .halted     (halted),
    .uPc        (uPc),
    .acc        (acc)
  );

  initial begin
    masterClk = 1'b0;
    forever #50 masterClk = ~masterClk;
  end

  function automatic cramWordT encodeWord(uOpE op, cramAddrT jump, immT imm);
    return {op, jump, imm};  // Opcode, jump, immediate from the top
  endfunction

  task automatic settle();
    @(negedge masterClk);
  endtask

  task automatic checkWord(string what, cramWordT exp, cramWordT act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: %s expected %h actual %h", curTest, what, exp, act);
      errCount++;
    end
  endtask

  task automatic checkHalf(string what, halfWordT exp, halfWordT act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: %s expected %0d actual %0d", curTest, what, exp, act);
      errCount++;
    end
  endtask

  task automatic checkHalfRange(string what, halfWordT lo, halfWordT hi, halfWordT act);
    if (act < lo || act > hi) begin
      $display("CHECK FAILED %s: %s expected %0d..%0d actual %0d", curTest, what, lo, hi, act);
      errCount++;
    end
  endtask

  task automatic checkAddr(string what, cramAddrT exp, cramAddrT act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: %s expected %0d actual %0d", curTest, what, exp, act);
      errCount++;
    end
  endtask

  task automatic checkBit(string what, logic exp, logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: %s expected %b actual %b", curTest, what, exp, act);
      errCount++;
    end
  endtask

  task automatic reportError(string msg);
    $display("ERROR %s: %s", curTest, msg);
    errCount++;
  endtask

  task automatic beginTest(string name);
    curTest  = name;
    testErrs = errCount;
    testsRun++;
  endtask

  task automatic endTest();
    if (errCount == testErrs) begin
      $display("PASS %s", curTest);
    end else begin
      testsFailed++;
      $display("FAIL %s with %0d errors", curTest, errCount - testErrs);
    end
  endtask

  // One strobe per command, function and data held steady throughout
  task automatic diagCmd(boardSelT board, logic [FUNC_W-1:0] func, diagDataT data);
    @(posedge masterClk);
    diagFunc   <= {board, func};
    diagData   <= data;
    diagStrobe <= 1'b1;
    repeat (CMD_CYCLES / 2) @(posedge masterClk);
    diagStrobe <= 1'b0;
    repeat (CMD_CYCLES / 2) @(posedge masterClk);
  endtask

  task automatic clockCmd(clkFuncE f, diagDataT d = '0);
    diagCmd(BOARD_CLK, f, d);
  endtask

  task automatic cramAddrLoad(cramAddrT a);
    diagCmd(BOARD_CRAM, cramLoadAddr, diagDataT'(a));
    shadowAddr = a;
  endtask

  task automatic cramWordWrite(cramWordT w);
    diagCmd(BOARD_CRAM, cramWrite, w);
    shadow[shadowAddr] = w;
    shadowAddr = shadowAddr + 1'b1;
  endtask

  task automatic cramReadCheck(string what);
    diagCmd(BOARD_CRAM, cramRead, '0);
    settle();
    checkWord(what, shadow[shadowAddr], cramWordT'(diagRdata));
    shadowAddr = shadowAddr + 1'b1;
  endtask

  task automatic resetStateTest();
    beginTest("resetState");
    settle();
    checkBit("machReset", 1'b1, machReset);
    checkBit("running", 1'b0, running);
    checkBit("halted", 1'b0, halted);
    checkAddr("uPc", '0, uPc);
    checkHalf("acc", '0, acc);
    checkWord("diagRdata", '0, cramWordT'(diagRdata));
    endTest();
  endtask

  task automatic cramLoadTest();
    int          i;
    logic [31:0] r;
    beginTest("cramLoad");
    cramAddrLoad('0);
    for (i = 0; i < PROG_WORDS; i++) begin
      r = $random(seed);
      cramWordWrite(r[CRAM_WORD_W-1:0]);
    end
    cramAddrLoad('0);
    for (i = 0; i < PROG_WORDS; i++) begin
      cramReadCheck($sformatf("word %0d", i));
    end
    endTest();
  endtask

  task automatic programRunTest();
    int       waited;
    halfWordT expAcc;
    beginTest("programRun");
    cramAddrLoad('0);
    cramWordWrite(encodeWord(uLoadImm, '0, immT'(5)));
    cramWordWrite(encodeWord(uAddImm, '0, immT'(7)));
    cramWordWrite(encodeWord(uAddImm, '0, immT'(100)));
    cramWordWrite(encodeWord(uHalt, '0, '0));
    expAcc = halfWordT'(5);
    expAcc = expAcc + halfWordT'(7);
    expAcc = expAcc + halfWordT'(100);
    clockCmd(clkClrReset);
    clockCmd(clkStart);
    waited = 0;
    settle();
    while (!halted && waited < HALT_BOUND) begin
      settle();
      waited++;
    end
    if (!halted) begin
      reportError("machine did not halt within the cycle bound");
    end
    checkHalf("acc", expAcc, acc);
    checkAddr("uPc", cramAddrT'(3), uPc);  // Halt holds its address
    checkBit("running", 1'b0, running);
    endTest();
  endtask

  task automatic stopStepTest();
    halfWordT recAcc;
    cramAddrT recPc;
    beginTest("stopStep");
    clockCmd(clkSetReset);                 // Writes need machine reset
    cramAddrLoad('0);
    cramWordWrite(encodeWord(uAddImm, '0, immT'(1)));
    cramWordWrite(encodeWord(uJump, '0, '0));
    clockCmd(clkClrReset);
    clockCmd(clkStart);
    repeat (RUN_WINDOW) @(posedge masterClk);
    clockCmd(clkStop);
    settle();
    checkBit("running after stop", 1'b0, running);
    recAcc = acc;
    recPc  = uPc;
    repeat (HOLD_WINDOW) @(posedge masterClk);
    settle();
    checkHalf("acc while stopped", recAcc, acc);
    checkAddr("uPc while stopped", recPc, uPc);
    repeat (4) clockCmd(clkStep);          // Two passes round the loop
    settle();
    checkHalf("acc after steps", recAcc + halfWordT'(2), acc);
    checkAddr("uPc after steps", recPc, uPc);
    endTest();
  endtask

  task automatic rateSelectTest();
    int       incs;
    halfWordT startAcc;
    halfWordT delta;
    beginTest("rateSelect");
    incs = RATE_WINDOW / (1 << RATE_SEL) / 2;  // Two ticks per increment
    clockCmd(clkSetRate, diagDataT'(RATE_SEL));
    clockCmd(clkStart);
    settle();
    startAcc = acc;
    repeat (RATE_WINDOW) @(posedge masterClk);
    settle();
    delta = acc - startAcc;
    checkHalfRange("acc increase", halfWordT'(incs - 1), halfWordT'(incs + 1), delta);
    checkBit("running", 1'b1, running);
    endTest();
  endtask

  task automatic crobarTest();
    int i;
    beginTest("crobarClear");
    settle();
    checkBit("running before crobar", 1'b1, running);
    @(posedge masterClk);
    crobar <= 1'b1;
    repeat (2) @(posedge masterClk);
    crobar <= 1'b0;
    settle();
    checkBit("machReset", 1'b1, machReset);
    checkBit("running", 1'b0, running);
    checkBit("halted", 1'b0, halted);
    checkAddr("uPc", '0, uPc);
    checkHalf("acc", '0, acc);
    cramAddrLoad('0);                      // CRAM survives the clear
    for (i = 0; i < PROG_WORDS; i++) begin
      cramReadCheck($sformatf("word %0d", i));
    end
    endTest();
  endtask

  initial begin
    arstN       = 1'b0;
    crobar      = 1'b0;
    diagStrobe  = 1'b0;
    diagFunc    = '0;
    diagData    = '0;
    shadowAddr  = '0;
    errCount    = 0;
    testsRun    = 0;
    testsFailed = 0;
    repeat (4) @(posedge masterClk);
    arstN <= 1'b1;
    resetStateTest();
    cramLoadTest();
    programRunTest();
    stopStepTest();
    rateSelectTest();
    crobarTest();
    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             testsRun, testsRun - testsFailed, testsFailed, errCount);
    if (errCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Twice the expected length of all tests
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge masterClk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

/* list.f */
src/eboxPkg.sv
src/diagBusIf.sv
src/diagDecode.sv
src/clkCtl.sv
src/cramStore.sv
src/microSeq.sv
src/eboxTop.sv
dv/eboxTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module eboxTb -f list.f -o eboxSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/eboxSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
